/* hdl/console_pkg.sv */
`default_nettype none

package console_pkg;

	// host command opcodes, anything else decodes as idle
	typedef enum logic [7:0] {
		CMD_IDLE      = 8'h00,
		CMD_CONNECT   = 8'hBB,
		CMD_CONNECTED = 8'hCC,
		CMD_END       = 8'hEE
	} console_cmd_e;

	// host register map
	localparam logic [2:0] REG_CMD_STATUS = 3'd0;
	localparam logic [2:0] REG_LOG_DATA   = 3'd1;
	localparam logic [2:0] REG_LOG_LEN    = 3'd2;

	// frame marker bytes
	localparam logic [7:0] FRAME_SYN = 8'h16;
	localparam logic [7:0] FRAME_ACK = 8'h06;
	localparam logic [7:0] FRAME_EOT = 8'h04;

	// status byte layout
	localparam int STATUS_DONE_BIT = 0;
	localparam int STATUS_BUSY_BIT = 1;

endpackage

`default_nettype wire

/* hdl/host_port.sv */
`timescale 1ns/1ps
`default_nettype none

module host_port import console_pkg::*; (
	input  wire        clk,
	input  wire        rst_n_i,
	input  wire  [2:0] addr_i,
	input  wire        read_i,
	input  wire        write_i,
	input  wire  [7:0] writedata_i,
	input  wire        busy_i,
	input  wire        done_i,
	input  wire  [7:0] log_data_i,
	input  wire  [7:0] log_len_i,
	output logic [7:0] readdata_o,
	output logic       cmd_connect_o,
	output logic       cmd_connected_o,
	output logic       cmd_end_o,
	output logic       log_read_o
);

	console_cmd_e wr_cmd;
	logic         pending;
	logic         accept;
	logic [7:0]   status;
	logic [7:0]   rd_mux;

	// decode of a command register write
	always_comb begin
		wr_cmd = CMD_IDLE;
		if (write_i && addr_i == REG_CMD_STATUS) begin
			case (writedata_i)
				CMD_CONNECT, CMD_CONNECTED, CMD_END: wr_cmd = console_cmd_e'(writedata_i);
				default: wr_cmd = CMD_IDLE;
			endcase
		end
	end

	// a pulse in flight counts as busy too
	assign pending = cmd_connect_o | cmd_connected_o | cmd_end_o;
	assign accept  = !busy_i && !pending;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cmd_connect_o   <= 1'b0;
			cmd_connected_o <= 1'b0;
			cmd_end_o       <= 1'b0;
		end else begin
			cmd_connect_o   <= accept && wr_cmd == CMD_CONNECT;
			cmd_connected_o <= accept && wr_cmd == CMD_CONNECTED;
			cmd_end_o       <= accept && wr_cmd == CMD_END;
		end
	end

	always_comb begin
		status = 8'h00;
		status[STATUS_DONE_BIT] = done_i;
		status[STATUS_BUSY_BIT] = busy_i | pending;
	end

	always_comb begin
		case (addr_i)
			REG_CMD_STATUS: rd_mux = status;
			REG_LOG_DATA:   rd_mux = log_data_i;
			REG_LOG_LEN:    rd_mux = log_len_i;
			default:        rd_mux = 8'h00;
		endcase
	end

	// log pointer advances on the same edge that samples the byte
	assign log_read_o = read_i && addr_i == REG_LOG_DATA;

	// one cycle read latency and the value holds until the next read
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			readdata_o <= 8'h00;
		end else if (read_i) begin
			readdata_o <= rd_mux;
		end
	end

	// a command pulse only ever reaches idle engines
	a_one_cmd: assert property (@(posedge clk) disable iff (!rst_n_i)
		pending |-> !busy_i);

endmodule

`default_nettype wire

/* hdl/initiator_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module initiator_engine import console_pkg::*; #(
	parameter logic [7:0] INIT_ID = 8'h01,
	parameter logic [7:0] ACC_ID  = 8'h02
) (
	input  wire        clk,
	input  wire        rst_n_i,
	input  wire        cmd_connect_i,
	input  wire        cmd_end_i,
	output logic [7:0] byte_o,
	output logic       we_o,
	output logic       end_o,
	output logic       syn_sent_o,
	output logic       busy_o
);

	typedef enum logic [1:0] {
		IDLE,
		SEND_SYN,
		OPEN,
		SEND_EOT
	} init_state_e;

	init_state_e state;
	logic [1:0]  cnt;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= IDLE;
			cnt   <= 2'd0;
		end else begin
			case (state)
				IDLE: begin
					cnt <= 2'd0;
					if (cmd_connect_i)
						state <= SEND_SYN;
				end
				SEND_SYN: begin
					// three byte frame
					if (cnt == 2'd2) begin
						state <= OPEN;
						cnt   <= 2'd0;
					end else begin
						cnt <= cnt + 2'd1;
					end
				end
				OPEN: begin
					cnt <= 2'd0;
					if (cmd_end_i)
						state <= SEND_EOT;
				end
				SEND_EOT: begin
					if (cnt == 2'd1) begin
						state <= IDLE;
						cnt   <= 2'd0;
					end else begin
						cnt <= cnt + 2'd1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_comb begin
		byte_o = 8'h00;
		case (state)
			SEND_SYN: begin
				case (cnt)
					2'd0:    byte_o = FRAME_SYN;
					2'd1:    byte_o = INIT_ID;
					default: byte_o = ACC_ID;
				endcase
			end
			SEND_EOT: byte_o = (cnt == 2'd0) ? FRAME_EOT : INIT_ID;
			default:  byte_o = 8'h00;
		endcase
	end

	assign we_o       = state == SEND_SYN || state == SEND_EOT;
	assign busy_o     = we_o;
	// marks the last EOT byte for the acceptor
	assign end_o      = state == SEND_EOT && cnt == 2'd1;
	assign syn_sent_o = state == OPEN;

endmodule

`default_nettype wire

/* hdl/acceptor_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module acceptor_engine import console_pkg::*; #(
	parameter logic [7:0] INIT_ID = 8'h01,
	parameter logic [7:0] ACC_ID  = 8'h02
) (
	input  wire        clk,
	input  wire        rst_n_i,
	input  wire        cmd_connected_i,
	input  wire        syn_sent_i,
	input  wire        init_end_i,
	output logic [7:0] byte_o,
	output logic       we_o,
	output logic       end_o,
	output logic       busy_o
);

	typedef enum logic [1:0] {
		IDLE,
		SEND_ACK,
		ACKED,
		SEND_EOT
	} acc_state_e;

	acc_state_e state;
	logic [1:0] cnt;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= IDLE;
			cnt   <= 2'd0;
		end else begin
			case (state)
				IDLE: begin
					cnt <= 2'd0;
					// session end still closes out an unacked session
					if (init_end_i)
						state <= SEND_EOT;
					else if (cmd_connected_i && syn_sent_i)
						state <= SEND_ACK;
				end
				SEND_ACK: begin
					if (cnt == 2'd2) begin
						state <= ACKED;
						cnt   <= 2'd0;
					end else begin
						cnt <= cnt + 2'd1;
					end
				end
				ACKED: begin
					cnt <= 2'd0;
					if (init_end_i)
						state <= SEND_EOT;
				end
				SEND_EOT: begin
					if (cnt == 2'd1) begin
						state <= IDLE;
						cnt   <= 2'd0;
					end else begin
						cnt <= cnt + 2'd1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_comb begin
		byte_o = 8'h00;
		case (state)
			SEND_ACK: begin
				case (cnt)
					2'd0:    byte_o = FRAME_ACK;
					2'd1:    byte_o = ACC_ID;
					default: byte_o = INIT_ID;
				endcase
			end
			SEND_EOT: byte_o = (cnt == 2'd0) ? FRAME_EOT : ACC_ID;
			default:  byte_o = 8'h00;
		endcase
	end

	assign we_o   = state == SEND_ACK || state == SEND_EOT;
	assign busy_o = we_o;
	assign end_o  = state == SEND_EOT && cnt == 2'd1;

	// initiator must not close while the ack frame is still going out
	a_no_end_in_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
		init_end_i |-> state != SEND_ACK);

endmodule

`default_nettype wire

/* hdl/message_log.sv */
`timescale 1ns/1ps
`default_nettype none

module message_log #(
	parameter int LOG_ADDR_W = 4
) (
	input  wire        clk,
	input  wire        rst_n_i,
	input  wire        clear_i,
	input  wire  [7:0] init_byte_i,
	input  wire        init_we_i,
	input  wire  [7:0] acc_byte_i,
	input  wire        acc_we_i,
	input  wire        sess_end_i,
	input  wire        read_i,
	output logic [7:0] data_o,
	output logic [7:0] len_o,
	output logic       done_o
);

	localparam int DEPTH = 1 << LOG_ADDR_W;

	logic [7:0]          mem [DEPTH];
	logic [LOG_ADDR_W:0] wr_ptr;
	logic [LOG_ADDR_W:0] rd_ptr;
	logic [LOG_ADDR_W:0] final_idx;
	logic [LOG_ADDR_W:0] rd_limit;
	logic                sess_end_q;
	logic                wr_en;
	logic [7:0]          wr_byte;
	logic                rd_avail;

	// only one engine talks at a time
	assign wr_en   = init_we_i | acc_we_i;
	assign wr_byte = init_we_i ? init_byte_i : acc_byte_i;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr[LOG_ADDR_W-1:0]] <= wr_byte;
	end

	// while the session runs, reads follow the bytes written so far
	assign rd_limit = done_o ? final_idx : wr_ptr;
	assign rd_avail = rd_ptr < rd_limit;
	assign data_o   = rd_avail ? mem[rd_ptr[LOG_ADDR_W-1:0]] : 8'h00;
	assign len_o    = 8'(final_idx);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			final_idx  <= '0;
			done_o     <= 1'b0;
			sess_end_q <= 1'b0;
		end else if (clear_i) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			final_idx  <= '0;
			done_o     <= 1'b0;
			sess_end_q <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			// length latched once the last byte has landed
			sess_end_q <= sess_end_i;
			if (sess_end_q) begin
				final_idx <= wr_ptr;
				done_o    <= 1'b1;
			end
			if (read_i && rd_avail)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	a_one_writer: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(init_we_i && acc_we_i));

	a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n_i)
		wr_en |-> wr_ptr < DEPTH);

endmodule

`default_nettype wire

/* hdl/sys_console.sv */
`timescale 1ns/1ps
`default_nettype none

module sys_console #(
	parameter logic [7:0] INIT_ID    = 8'h01,
	parameter logic [7:0] ACC_ID     = 8'h02,
	parameter int         LOG_ADDR_W = 4
) (
	input  wire        clk,
	input  wire        rst_n_i,
	input  wire  [2:0] addr_i,
	input  wire        read_i,
	input  wire        write_i,
	input  wire  [7:0] writedata_i,
	output wire  [7:0] readdata_o
);

	wire       cmd_connect;
	wire       cmd_connected;
	wire       cmd_end;
	wire       log_read;
	wire [7:0] init_byte;
	wire       init_we;
	wire       init_end;
	wire       syn_sent;
	wire       init_busy;
	wire [7:0] acc_byte;
	wire       acc_we;
	wire       sess_end;
	wire       acc_busy;
	wire       busy;
	wire [7:0] log_data;
	wire [7:0] log_len;
	wire       log_done;

	assign busy = init_busy | acc_busy;

	host_port u_host_port (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.addr_i          (addr_i),
		.read_i          (read_i),
		.write_i         (write_i),
		.writedata_i     (writedata_i),
		.busy_i          (busy),
		.done_i          (log_done),
		.log_data_i      (log_data),
		.log_len_i       (log_len),
		.readdata_o      (readdata_o),
		.cmd_connect_o   (cmd_connect),
		.cmd_connected_o (cmd_connected),
		.cmd_end_o       (cmd_end),
		.log_read_o      (log_read)
	);

	initiator_engine #(
		.INIT_ID (INIT_ID),
		.ACC_ID  (ACC_ID)
	) u_initiator (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.cmd_connect_i (cmd_connect),
		.cmd_end_i     (cmd_end),
		.byte_o        (init_byte),
		.we_o          (init_we),
		.end_o         (init_end),
		.syn_sent_o    (syn_sent),
		.busy_o        (init_busy)
	);

	acceptor_engine #(
		.INIT_ID (INIT_ID),
		.ACC_ID  (ACC_ID)
	) u_acceptor (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.cmd_connected_i (cmd_connected),
		.syn_sent_i      (syn_sent),
		.init_end_i      (init_end),
		.byte_o          (acc_byte),
		.we_o            (acc_we),
		.end_o           (sess_end),
		.busy_o          (acc_busy)
	);

	// a connect starts a fresh log
	message_log #(
		.LOG_ADDR_W (LOG_ADDR_W)
	) u_log (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.clear_i     (cmd_connect),
		.init_byte_i (init_byte),
		.init_we_i   (init_we),
		.acc_byte_i  (acc_byte),
		.acc_we_i    (acc_we),
		.sess_end_i  (sess_end),
		.read_i      (log_read),
		.data_o      (log_data),
		.len_o       (log_len),
		.done_o      (log_done)
	);

endmodule

`default_nettype wire

/* verif/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
	parameter int PERIOD = 4
) (
	output logic clk_o
);

	// free running, first rising edge at half a period
	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD / 2.0);
			clk_o = ~clk_o;
		end
	end

endmodule

`default_nettype wire

/* verif/tb_sys_console.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sys_console import console_pkg::*; ();

	localparam int         CLK_PERIOD = 4;
	localparam int         MAX_POLLS  = 16;
	localparam logic [7:0] INIT_ID    = 8'h01;
	localparam logic [7:0] ACC_ID     = 8'h02;

	typedef enum logic [1:0] {
		OP_WRITE,
		OP_READ,
		OP_WAIT
	} op_e;

	typedef struct packed {
		op_e        op;
		logic [2:0] addr;
		logic [7:0] wdata;
		logic [7:0] exp;
		logic       from_model;
	} entry_t;

	logic       clk;
	logic       rst_n;
	logic [2:0] addr;
	logic       read;
	logic       write;
	logic [7:0] writedata;
	wire  [7:0] readdata;

	entry_t     stim_q[$];
	logic [7:0] log_q[$];
	int         log_rd;
	int         log_len;
	bit         log_done;
	bit         cmd_busy;
	int         phase;
	integer     seed;
	int         value_errors;
	int         other_errors;
	bit         table_ready;

	clk_gen #(.PERIOD(CLK_PERIOD)) u_clk (.clk_o(clk));

	sys_console #(
		.INIT_ID (INIT_ID),
		.ACC_ID  (ACC_ID)
	) DUT (
		.clk         (clk),
		.rst_n_i     (rst_n),
		.addr_i      (addr),
		.read_i      (read),
		.write_i     (write),
		.writedata_i (writedata),
		.readdata_o  (readdata)
	);

	task automatic add_entry(input op_e op, input logic [2:0] a, input logic [7:0] d,
			input logic [7:0] e, input logic m);
		entry_t ent;
		ent.op         = op;
		ent.addr       = a;
		ent.wdata      = d;
		ent.exp        = e;
		ent.from_model = m;
		stim_q.push_back(ent);
	endtask

	task automatic build_table();
		// state right after reset
		add_entry(OP_READ, REG_CMD_STATUS, 8'h00, 8'h00, 1'b0);
		add_entry(OP_READ, REG_LOG_LEN, 8'h00, 8'h00, 1'b1);
		add_entry(OP_READ, REG_LOG_DATA, 8'h00, 8'h00, 1'b1);
		// connected before any SYN went out
		add_entry(OP_WRITE, REG_CMD_STATUS, CMD_CONNECTED, 8'h00, 1'b0);
		add_entry(OP_WAIT, REG_CMD_STATUS, 8'h00, 8'h00, 1'b0);
		add_entry(OP_WRITE, REG_CMD_STATUS, CMD_CONNECT, 8'h00, 1'b0);
		add_entry(OP_WAIT, REG_CMD_STATUS, 8'h00, 8'h00, 1'b0);
		add_entry(OP_WRITE, REG_CMD_STATUS, CMD_CONNECTED, 8'h00, 1'b0);
		// lands while the ACK frame is still going out
		add_entry(OP_WRITE, REG_CMD_STATUS, CMD_END, 8'h00, 1'b0);
		add_entry(OP_WAIT, REG_CMD_STATUS, 8'h00, 8'h00, 1'b0);
		// already acked, so no second ACK frame
		add_entry(OP_WRITE, REG_CMD_STATUS, CMD_CONNECTED, 8'h00, 1'b0);
		add_entry(OP_WAIT, REG_CMD_STATUS, 8'h00, 8'h00, 1'b0);
		repeat (6) add_entry(OP_READ, REG_LOG_DATA, 8'h00, 8'h00, 1'b1);
		add_entry(OP_WRITE, REG_CMD_STATUS, CMD_END, 8'h00, 1'b0);
		add_entry(OP_WAIT, REG_CMD_STATUS, 8'h00, 8'h00, 1'b0);
		add_entry(OP_READ, REG_CMD_STATUS, 8'h00, 8'(1 << STATUS_DONE_BIT), 1'b0);
		add_entry(OP_READ, REG_LOG_LEN, 8'h00, 8'h00, 1'b1);
		// four EOT bytes, then one read past the end
		repeat (5) add_entry(OP_READ, REG_LOG_DATA, 8'h00, 8'h00, 1'b1);
		add_entry(OP_WRITE, REG_CMD_STATUS, CMD_CONNECT, 8'h00, 1'b0);
		add_entry(OP_WAIT, REG_CMD_STATUS, 8'h00, 8'h00, 1'b0);
		add_entry(OP_READ, REG_CMD_STATUS, 8'h00, 8'h00, 1'b0);
		add_entry(OP_READ, REG_LOG_LEN, 8'h00, 8'h00, 1'b1);
		repeat (3) add_entry(OP_READ, REG_LOG_DATA, 8'h00, 8'h00, 1'b1);
	endtask

	// reference model of the session, fed with every command the host writes
	task automatic track_command(input logic [7:0] opcode);
		if (!cmd_busy) begin
			case (opcode)
				CMD_CONNECT: begin
					cmd_busy = 1'b1;
					log_q.delete();
					log_rd   = 0;
					log_len  = 0;
					log_done = 1'b0;
					if (phase == 0) begin
						log_q.push_back(FRAME_SYN);
						log_q.push_back(INIT_ID);
						log_q.push_back(ACC_ID);
						phase = 1;
					end
				end
				CMD_CONNECTED: begin
					cmd_busy = 1'b1;
					if (phase == 1) begin
						log_q.push_back(FRAME_ACK);
						log_q.push_back(ACC_ID);
						log_q.push_back(INIT_ID);
						phase = 2;
					end
				end
				CMD_END: begin
					cmd_busy = 1'b1;
					if (phase != 0) begin
						log_q.push_back(FRAME_EOT);
						log_q.push_back(INIT_ID);
						log_q.push_back(FRAME_EOT);
						log_q.push_back(ACC_ID);
						log_len  = log_q.size();
						log_done = 1'b1;
						phase    = 0;
					end
				end
				default: ;
			endcase
		end
	endtask

	function automatic logic [7:0] next_log_byte();
		int limit;
		limit = log_done ? log_len : log_q.size();
		if (log_rd < limit) begin
			next_log_byte = log_q[log_rd];
			log_rd++;
		end else begin
			next_log_byte = 8'h00;
		end
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic drive_write(input logic [2:0] a, input logic [7:0] d);
		addr      = a;
		writedata = d;
		write     = 1'b1;
		next_cycle();
		write = 1'b0;
	endtask

	task automatic drive_read(input logic [2:0] a, output logic [7:0] d);
		addr = a;
		read = 1'b1;
		next_cycle();
		read = 1'b0;
		d    = readdata;
	endtask

	task automatic check_read(input int idx, input logic [7:0] expected, input logic [7:0] got);
		assert (got === expected) else begin
			$display("[ERROR] %0t ns readdata_o expected %02h actual %02h at entry %0d",
				$time, expected, got, idx);
			value_errors++;
		end
	endtask

	task automatic poll_until_idle(input int idx);
		logic [7:0] st;
		int         polls;
		polls = 0;
		drive_read(REG_CMD_STATUS, st);
		while (st[STATUS_BUSY_BIT] && polls < MAX_POLLS) begin
			drive_read(REG_CMD_STATUS, st);
			polls++;
		end
		assert (!st[STATUS_BUSY_BIT]) else begin
			$display("busy status never cleared while waiting at entry %0d", idx);
			other_errors++;
		end
		cmd_busy = 1'b0;
	endtask

	initial begin : stimulus
		entry_t     e;
		logic [7:0] got;
		logic [7:0] expected;
		int         gap;
		rst_n        = 1'b0;
		addr         = 3'd0;
		read         = 1'b0;
		write        = 1'b0;
		writedata    = 8'h00;
		seed         = 32'hae6a;
		log_rd       = 0;
		log_len      = 0;
		log_done     = 1'b0;
		cmd_busy     = 1'b0;
		phase        = 0;
		value_errors = 0;
		other_errors = 0;
		build_table();
		table_ready = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		foreach (stim_q[i]) begin
			gap = $unsigned($random(seed)) % 4;
			repeat (gap) next_cycle();
			e = stim_q[i];
			case (e.op)
				OP_WRITE: begin
					drive_write(e.addr, e.wdata);
					if (e.addr == REG_CMD_STATUS)
						track_command(e.wdata);
				end
				OP_READ: begin
					drive_read(e.addr, got);
					if (!e.from_model)
						expected = e.exp;
					else if (e.addr == REG_LOG_DATA)
						expected = next_log_byte();
					else
						expected = 8'(log_len);
					check_read(i, expected, got);
				end
				default: poll_until_idle(i);
			endcase
		end
		next_cycle();
		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// twenty cycles per table entry plus the reset
	initial begin : watchdog
		wait (table_ready);
		#((stim_q.size() * 20 + 10) * CLK_PERIOD);
		$display("watchdog expired before the stimulus table finished");
		$display("errors: %0d value, %0d other", value_errors, other_errors + 1);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
hdl/console_pkg.sv
hdl/host_port.sv
hdl/initiator_engine.sv
hdl/acceptor_engine.sv
hdl/message_log.sv
hdl/sys_console.sv
verif/clk_gen.sv
verif/tb_sys_console.sv

/* Bender.yml */
package:
  name: sys_console

sources:
  - hdl/console_pkg.sv
  - hdl/host_port.sv
  - hdl/initiator_engine.sv
  - hdl/acceptor_engine.sv
  - hdl/message_log.sv
  - hdl/sys_console.sv
  - target: test
    files:
      - verif/clk_gen.sv
      - verif/tb_sys_console.sv
